//--- sim/fcpegn_tests.txt
// columns in hex: mode(sync,parity) _ dn _ byte _ mask _ symbol count _ frame bits
// frame bits hold the first symbol in bit 11, unused low bits are 0
0_0_a5_03_8_a50
1_1_3c_01_9_3c8
2_1_c3_02_b_586
3_0_81_00_b_a06
3_0_5e_03_c_abc
2_0_7f_01_b_afe
1_0_00_02_9_008
0_1_ff_00_8_ff0
2_1_01_03_a_404
1_1_96_01_9_968

//--- vlog.f
hdl/fcp_pkg.sv
hdl/fcp_tx_if.sv
hdl/fcp_regs.sv
hdl/fcp_ui_timer.sv
hdl/fcp_tx_shifter.sv
hdl/fcp_tx_ctrl.sv
hdl/fcpegn.sv
sim/fcpegn_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fcpegn testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f vlog.f --top-module fcpegn_tb -o fcpegn_sim
./obj_dir/fcpegn_sim > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation passed"

//--- sim/fcpegn_tb.sv
// testbench top with clock, reset, file-driven frame tests, symbol sampling, checks and watchdog
`timescale 1ns/10ps

module fcpegn_tb;
	import fcp_pkg::*;

	localparam int US_CLKS   = 2;
	localparam int UI_US     = 16;
	localparam int CLK_NS    = 8;
	localparam int SYNC_CYC  = ((UI_US + 2) / 4) * US_CLKS; // rounded quarter UI
	localparam int UI_CYC    = UI_US * US_CLKS;
	localparam int MAX_FRAME = 3 * SYNC_CYC + 9 * UI_CYC;   // 3 syncs, byte, parity
	localparam int MAX_TESTS = 32;

	logic       clk;
	logic       srstz;
	logic [3:0] wr;
	logic [7:0] wdat;
	logic       dn;
	logic       acc_int;
	logic [7:0] ctl;
	logic [7:0] sta;
	logic [7:0] msk;
	logic [7:0] dat;
	logic       tx_en;
	logic       tx_dat;
	logic       intr;

	logic [39:0] tests [0:MAX_TESTS-1]; // mode dn byte mask nsym bits
	int ntests;
	bit loaded;
	int checks;
	int errors;
	int intr_cnt = 0; // running total of intr pulses

	fcpegn #(.US_CLKS(US_CLKS), .UI_US(UI_US)) fcpegn_inst (
		.clk(clk), .srstz(srstz), .wr(wr), .wdat(wdat), .dn(dn), .acc_int(acc_int),
		.ctl(ctl), .sta(sta), .msk(msk), .dat(dat), .tx_en(tx_en), .tx_dat(tx_dat),
		.intr(intr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	always @(negedge clk) begin
		if (intr)
			intr_cnt = intr_cnt + 1; // counted mid-cycle where intr is stable
	end

	//----------------------------------------------------------------------
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail: time %0t, %s = %h, expected %h", $time, name, got, exp);
		end
	endtask

	// one strobe cycle that returns 1 ns after the next edge
	task automatic write_reg(input int idx, input logic [7:0] v);
		wr   = 4'(1 << idx);
		wdat = v;
		@(posedge clk);
		#1 wr = 4'b0000;
	endtask

	task automatic pulse_acc_int;
		acc_int = 1'b1;
		@(posedge clk);
		#1 acc_int = 1'b0;
	endtask

	function automatic logic [7:0] ctl_word(input logic [1:0] m);
		logic [7:0] w;
		w             = 8'h00;
		w[ctl_en]     = 1'b1;
		w[ctl_sync]   = m[1];
		w[ctl_parity] = m[0];
		return w;
	endfunction

	// symbols of one frame with the first one in bit 11
	task automatic build_frame(input logic [1:0] m, input logic d, input logic [7:0] b,
			output int nsync, output int n, output logic [11:0] bits);
		logic [7:0] bb;
		logic       sym;
		int         j;
		nsync = 0;
		if (m[1])
			nsync = (d == b[7]) ? 3 : 2; // one more sync when dn already sits at bit 7
		n    = 0;
		bits = 12'h000;
		bb   = b;
		for (j = nsync - 1; j >= 0; j--) begin
			sym  = b[7] ^ (j % 2 == 0); // alternating and ending on ~bit7
			bits = {bits[10:0], sym};
			n++;
		end
		for (j = 0; j < 8; j++) begin
			bits = {bits[10:0], bb[7]}; // msb first
			bb   = bb << 1;
			n++;
		end
		if (m[0]) begin
			bits = {bits[10:0], ~(^b)}; // odd parity
			n++;
		end
		bits = bits << (12 - n);
	endtask

	task automatic wait_tx_en(output bit ok);
		int n;
		ok = 1'b0;
		n  = 0;
		while (!ok && n < 16) begin
			if (tx_en)
				ok = 1'b1;
			else begin
				@(posedge clk);
				#1 n++;
			end
		end
		if (!ok) begin
			errors++;
			$display("Error: tx_en did not rise within 16 cycles of a data write, time %0t",
				$time);
		end else
			check("tx_en delay", 32'(n), 32'd0); // high right after the write edge
	endtask

	//----------------------------------------------------------------------
	// runs from 1 ns into the first frame cycle to 1 ns past the last
	task automatic play_frame(input int idx, input bit chain, input int nxt);
		logic [39:0] t;
		logic [39:0] tn;
		logic [11:0] bits;
		int          nsync;
		int          n;
		int          s;
		int          len;
		int          used;
		t  = tests[idx];
		tn = tests[nxt];
		build_frame(t[37:36], t[32], t[31:24], nsync, n, bits);
		check("file nsym", 32'(t[15:12]), 32'(n));
		check("file bits", 32'(t[11:0]), 32'(bits));
		for (s = 0; s < n; s++) begin
			len  = (s < nsync) ? SYNC_CYC : UI_CYC;
			used = len / 2;
			repeat (used) @(posedge clk);
			#1;
			check("tx_dat", 32'(tx_dat), 32'(bits[11]));
			check("tx_en", 32'(tx_en), 32'd1);
			bits = bits << 1;
			if (s == 0 && chain) begin
				dn = tn[32]; // only sampled at the reload
				write_reg(reg_ctl, ctl_word(tn[37:36]));
				write_reg(reg_dat, tn[31:24]);
				used += 2;
			end
			repeat (len - used) @(posedge clk);
			#1;
		end
	endtask

	task automatic run_single(input int idx);
		logic [39:0] t;
		bit          ok;
		int          base;
		t  = tests[idx];
		dn = t[32];
		write_reg(reg_ctl, ctl_word(t[37:36]));
		write_reg(reg_msk, t[23:16]);
		base = intr_cnt;
		write_reg(reg_dat, t[31:24]);
		wait_tx_en(ok);
		if (ok) begin
			play_frame(idx, 1'b0, idx);
			check("tx_en", 32'(tx_en), 32'd0); // falls as the last symbol ends
			check("sta", 32'(sta), 32'h03);
			check("intr pulses", 32'(intr_cnt - base), 32'(t[17]) + 32'(t[16]));
			write_reg(reg_sta, 8'h03);
			check("sta", 32'(sta), 32'h00);
		end
	endtask

	// all lines as one stream with the next byte and mode written during each frame
	task automatic run_chain;
		logic [39:0] t;
		bit          ok;
		int          base;
		int          i;
		t  = tests[0];
		dn = t[32];
		write_reg(reg_ctl, ctl_word(t[37:36]));
		write_reg(reg_msk, 8'h03);
		base = intr_cnt;
		write_reg(reg_dat, t[31:24]);
		wait_tx_en(ok);
		for (i = 0; ok && i < ntests; i++) begin
			play_frame(i, i + 1 < ntests, i + 1);
			if (i + 1 < ntests)
				check("tx_en between frames", 32'(tx_en), 32'd1);
		end
		if (ok) begin
			check("tx_en", 32'(tx_en), 32'd0);
			check("sta", 32'(sta), 32'h03);
			check("intr pulses", 32'(intr_cnt - base), 32'(ntests + 1)); // loads + one end
		end
	endtask

	//----------------------------------------------------------------------
	initial begin
		int  i;
		int  base;
		bit  seen;
		srstz   = 1'b0;
		wr      = 4'b0000;
		wdat    = 8'h00;
		dn      = 1'b0;
		acc_int = 1'b0;
		for (i = 0; i < MAX_TESTS; i++)
			tests[i] = '1; // end marker since mode f is not a mode
		$readmemh("sim/fcpegn_tests.txt", tests);
		ntests = 0;
		while (ntests < MAX_TESTS - 1 && tests[ntests] !== '1)
			ntests++;
		loaded = 1'b1;
		if (ntests == 0) begin
			errors++;
			$display("Error: no test lines read from sim/fcpegn_tests.txt");
		end

		repeat (8) @(posedge clk);
		#1 srstz = 1'b1;

		// reset values and readback
		check("tx_en", 32'(tx_en), 32'd0);
		check("tx_dat", 32'(tx_dat), 32'd0);
		check("intr", 32'(intr), 32'd0);
		check("ctl", 32'(ctl), 32'h80); // only keep_empty
		check("sta", 32'(sta), 32'h00);
		check("msk", 32'(msk), 32'h00);
		check("dat", 32'(dat), 32'h00);
		dn = 1'b1;
		write_reg(reg_ctl, 8'h13);
		check("ctl", 32'(ctl), 32'hb3);
		write_reg(reg_ctl, 8'hee); // upper bits not stored
		check("ctl", 32'(ctl), 32'hae);
		write_reg(reg_msk, 8'h5a);
		check("msk", 32'(msk), 32'h5a);
		dn = 1'b0;
		write_reg(reg_ctl, 8'h00);
		check("ctl", 32'(ctl), 32'h80);

		for (i = 0; i < ntests; i++)
			run_single(i);
		if (ntests > 0)
			run_chain();

		//------------------------------------------------------------------
		// status clear and acc_int
		write_reg(reg_msk, 8'h80);
		base = intr_cnt;
		pulse_acc_int();
		check("sta", 32'(sta), 32'(8'h80 | (ntests > 0 ? 8'h03 : 8'h00)));
		check("intr pulses", 32'(intr_cnt - base), 32'd1);
		write_reg(reg_sta, 8'h03);
		check("sta", 32'(sta), 32'h80);
		write_reg(reg_sta, 8'h80);
		check("sta", 32'(sta), 32'h00);
		write_reg(reg_msk, 8'h00);
		base = intr_cnt;
		pulse_acc_int(); // unmasked so status only
		check("intr pulses", 32'(intr_cnt - base), 32'd0);
		check("sta", 32'(sta), 32'h80);
		write_reg(reg_sta, 8'h80);
		check("sta", 32'(sta), 32'h00);

		// data write with the engine off
		write_reg(reg_ctl, 8'h00);
		write_reg(reg_msk, 8'h03);
		base = intr_cnt;
		write_reg(reg_dat, 8'h6b);
		seen = 1'b0;
		repeat (2 * UI_CYC) begin
			if (tx_en)
				seen = 1'b1;
			@(posedge clk);
			#1;
		end
		check("tx_en while disabled", 32'(seen), 32'd0);
		check("dat", 32'(dat), 32'h6b);
		check("intr pulses", 32'(intr_cnt - base), 32'd0);

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog allowing two frames per line plus setup
	initial begin
		int limit;
		wait (loaded);
		limit = (ntests * (2 * MAX_FRAME + 20) + 600) * CLK_NS;
		#(limit);
		$display("Error: watchdog stopped the run after %0d ns, a wait never completed", limit);
		$display("checks %0d, errors %0d", checks, errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- hdl/fcpegn.sv
// fcpegn module: FCP slave transmit engine top, registers, sequencer, timer and shifter
`timescale 1ns/10ps

module fcpegn #(
	parameter int US_CLKS = 12, // clocks per us
	parameter int UI_US   = 160 // us per UI
) (
	input  logic       clk,
	input  logic       srstz,
	input  logic [3:0] wr,      // ctl/sta/msk/dat write strobes (1T)
	input  logic [7:0] wdat,
	input  logic       dn,      // debounced D-
	input  logic       acc_int,
	output logic [7:0] ctl,
	output logic [7:0] sta,
	output logic [7:0] msk,
	output logic [7:0] dat,
	output logic       tx_en,   // high for the whole transmission
	output logic       tx_dat,
	output logic       intr     // 1T
);
	import fcp_pkg::*;

	fcp_mode_t mode;
	sync_len_t sync_len;
	logic      dat_wr;
	logic      fcp_en;
	logic      restart;
	logic      quarter;
	logic      sym_end;

	fcp_tx_if tx_bus ();

	//----------------------------------------------------------------------
	fcp_regs u_regs (
		.clk(clk), .srstz(srstz), .wr(wr), .wdat(wdat), .dn(dn), .acc_int(acc_int),
		.tx(tx_bus.regs), .ctl(ctl), .sta(sta), .msk(msk), .dat(dat),
		.dat_wr(dat_wr), .fcp_en(fcp_en), .mode(mode), .intr(intr)
	);

	fcp_tx_ctrl u_ctrl (
		.clk(clk), .srstz(srstz), .dat_wr(dat_wr), .fcp_en(fcp_en), .mode(mode),
		.sync_len(sync_len), .sym_end(sym_end), .tx(tx_bus.ctrl),
		.restart(restart), .quarter(quarter)
	);

	fcp_ui_timer #(.US_CLKS(US_CLKS), .UI_US(UI_US)) u_timer (
		.clk(clk), .srstz(srstz), .restart(restart), .quarter(quarter),
		.run(tx_bus.on_tx), .sym_end(sym_end)
	);

	fcp_tx_shifter u_shft (
		.clk(clk), .srstz(srstz), .tx(tx_bus.shft), .dat(dat), .wdat(wdat),
		.mode(mode), .dn(dn), .sync_len(sync_len), .tx_dat(tx_dat)
	);

	assign tx_en = tx_bus.on_tx;

endmodule

//--- hdl/fcp_tx_ctrl.sv
// fcp_tx_ctrl module: transmit sequencer FSM, symbol counter and buffer-empty tracking
`timescale 1ns/10ps

module fcp_tx_ctrl (
	input  logic               clk,
	input  logic               srstz,
	input  logic               dat_wr,
	input  logic               fcp_en,
	input  fcp_pkg::fcp_mode_t mode,
	input  fcp_pkg::sync_len_t sync_len,
	input  logic               sym_end,
	fcp_tx_if.ctrl             tx,
	output logic               restart,
	output logic               quarter
);
	import fcp_pkg::*;

	tx_state_t state;
	sym_cnt_t  sym_cnt;   // symbols done in this frame
	sym_cnt_t  sym_last;  // index of the final symbol
	logic      keep_empty;
	logic      on_tx;
	logic      has_sync;
	logic      has_par;
	logic      start;
	logic      frame_end;
	logic      reload;
	logic      load;

	// framing mode to sequencer state
	function automatic tx_state_t mode_state(input fcp_mode_t m);
		case ({m.sync, m.parity})
			2'b00:   mode_state = tx_plain;
			2'b01:   mode_state = tx_par;
			2'b10:   mode_state = tx_sync;
			default: mode_state = tx_sync_par;
		endcase
	endfunction

	//----------------------------------------------------------------------
	assign on_tx    = (state != idle);
	assign has_sync = (state == tx_sync) || (state == tx_sync_par);
	assign has_par  = (state == tx_par) || (state == tx_sync_par);

	// sync_len+1 syncs, 8 data bits, optional parity
	assign sym_last = (has_sync ? {2'b00, sync_len} + 4'd1 : 4'd0) + 4'd7 + {3'b000, has_par};

	assign start     = (state == idle) & dat_wr & fcp_en;
	assign frame_end = on_tx & sym_end & (sym_cnt == sym_last);
	assign reload    = frame_end & ~keep_empty; // back to back
	assign load      = start | reload;

	assign quarter = has_sync & (sym_cnt <= {2'b00, sync_len}); // still in sync part
	assign restart = start;

	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz) begin
			state   <= idle;
			sym_cnt <= '0;
		end else if (load) begin
			state   <= mode_state(mode); // mode sampled at load
			sym_cnt <= '0;
		end else if (frame_end) begin
			state   <= idle; // nothing pending
			sym_cnt <= '0;
		end else if (on_tx && sym_end) begin
			sym_cnt <= sym_cnt + 1'b1;
		end
	end

	// start takes the written byte at once, a later write leaves one pending
	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz)
			keep_empty <= 1'b1;
		else if (start)
			keep_empty <= 1'b1;
		else if (dat_wr)
			keep_empty <= 1'b0;
		else if (reload)
			keep_empty <= 1'b1;
	end

	assign tx.start      = start;
	assign tx.reload     = reload;
	assign tx.shift      = on_tx & sym_end & ~frame_end;
	assign tx.dbuf_empty = load; // data register just copied out
	assign tx.tx_end     = frame_end & keep_empty;
	assign tx.keep_empty = keep_empty;
	assign tx.on_tx      = on_tx;

endmodule

//--- hdl/fcp_tx_shifter.sv
// fcp_tx_shifter module: frame builder, 12-bit shift buffer and sync length register
`timescale 1ns/10ps

module fcp_tx_shifter (
	input  logic               clk,
	input  logic               srstz,
	fcp_tx_if.shft             tx,
	input  logic [7:0]         dat,  // pending byte, for reload
	input  logic [7:0]         wdat, // write data, for start
	input  fcp_pkg::fcp_mode_t mode,
	input  logic               dn,
	output fcp_pkg::sync_len_t sync_len,
	output logic               tx_dat
);
	import fcp_pkg::*;

	logic [7:0] src;       // byte being framed
	logic       par_bit;   // odd parity, 0 when unused
	logic [8:0] body;      // byte then parity slot
	logic       load;
	sync_len_t  len_nxt;
	frame_t     frame_nxt;
	frame_t     shft_buf;

	assign load    = tx.start | tx.reload;
	assign src     = tx.start ? wdat : dat;
	assign par_bit = mode.parity & ~(^src);
	assign body    = {src, par_bit};

	// three syncs when dn already sits at bit 7, else two
	assign len_nxt = !mode.sync ? 2'd0 : (dn == src[7]) ? 2'd2 : 2'd1;

	//----------------------------------------------------------------------
	// sync symbols alternate and end on ~bit7
	always_comb begin
		case (len_nxt)
			2'd2:    frame_nxt = {~src[7], src[7], ~src[7], body};
			2'd1:    frame_nxt = {src[7], ~src[7], body, 1'b0};
			default: frame_nxt = {body, 3'b000};
		endcase
	end

	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz)
			sync_len <= '0;
		else if (load)
			sync_len <= len_nxt;
	end

	always_ff @(posedge clk) begin
		if (load)
			shft_buf <= frame_nxt;
		else if (tx.shift)
			shft_buf <= shft_buf << 1; // msb first
	end

	assign tx_dat = shft_buf[11] & tx.on_tx; // line low outside a frame

endmodule

//--- hdl/fcp_ui_timer.sv
// fcp_ui_timer module: microsecond divider and symbol interval counter with sym_end strobe
`timescale 1ns/10ps

module fcp_ui_timer #(
	parameter int US_CLKS = 12, // clocks per us
	parameter int UI_US   = 160 // us per UI
) (
	input  logic clk,
	input  logic srstz,
	input  logic restart, // realign to a new frame
	input  logic quarter, // sync symbol, quarter UI
	input  logic run,
	output logic sym_end  // last cycle of the symbol
);

	localparam int QUARTER_US = (UI_US + 2) / 4; // rounded
	localparam int UW         = $clog2(US_CLKS + 1);
	localparam int IW         = $clog2(UI_US + 1);

	logic [UW-1:0] us_cnt;
	logic          us_tick;   // last clock of each us
	logic [IW-1:0] intv_cnt;  // whole us elapsed in the symbol
	logic [IW-1:0] intv_last;

	assign us_tick   = (us_cnt == UW'(US_CLKS - 1));
	assign intv_last = quarter ? IW'(QUARTER_US - 1) : IW'(UI_US - 1);
	assign sym_end   = run & us_tick & (intv_cnt == intv_last);

	//----------------------------------------------------------------------
	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz)
			us_cnt <= '0;
		else if (!run || restart || us_tick)
			us_cnt <= '0;
		else
			us_cnt <= us_cnt + 1'b1;
	end

	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz)
			intv_cnt <= '0;
		else if (!run || restart || sym_end)
			intv_cnt <= '0; // next symbol starts from zero
		else if (us_tick)
			intv_cnt <= intv_cnt + 1'b1;
	end

endmodule

//--- hdl/fcp_regs.sv
// fcp_regs module: control, status, mask and data registers, interrupt strobe
`timescale 1ns/10ps

module fcp_regs (
	input  logic               clk,
	input  logic               srstz,
	input  logic [3:0]         wr,      // one strobe per register
	input  logic [7:0]         wdat,
	input  logic               dn,      // debounced D- level
	input  logic               acc_int, // accessory interrupt event
	fcp_tx_if.regs             tx,
	output logic [7:0]         ctl,
	output logic [7:0]         sta,
	output logic [7:0]         msk,
	output logic [7:0]         dat,
	output logic               dat_wr,
	output logic               fcp_en,
	output fcp_pkg::fcp_mode_t mode,
	output logic               intr
);
	import fcp_pkg::*;

	logic [ctl_en:0] ctl_q;   // writable control bits
	logic [7:0]      sta_set; // status events this cycle
	logic [7:0]      sta_clr; // write-one-to-clear mask

	//----------------------------------------------------------------------
	// control / mask / data
	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz) begin
			ctl_q <= '0;
			msk   <= '0;
			dat   <= '0;
		end else begin
			if (wr[reg_ctl]) ctl_q <= wdat[ctl_en:0];
			if (wr[reg_msk]) msk   <= wdat;
			if (wr[reg_dat]) dat   <= wdat; // overwrites a pending byte
		end
	end

	// readback merges the live tx levels and dn
	always_comb begin
		ctl                 = '0;
		ctl[ctl_en:0]       = ctl_q;
		ctl[ctl_dn]         = dn;
		ctl[ctl_on_tx]      = tx.on_tx;
		ctl[ctl_keep_empty] = tx.keep_empty;
	end

	assign dat_wr = wr[reg_dat];
	assign fcp_en = ctl_q[ctl_en];
	assign mode   = '{sync: ctl_q[ctl_sync], parity: ctl_q[ctl_parity]};

	//----------------------------------------------------------------------
	// status, set wins over a same-cycle clear
	always_comb begin
		sta_set                 = '0;
		sta_set[sta_tx_end]     = tx.tx_end;
		sta_set[sta_dbuf_empty] = tx.dbuf_empty;
		sta_set[sta_acc_int]    = acc_int;
	end

	assign sta_clr = wr[reg_sta] ? wdat : 8'h00;

	always_ff @(posedge clk or negedge srstz) begin
		if (!srstz)
			sta <= '0;
		else
			sta <= (sta & ~sta_clr) | sta_set;
	end

	// interrupt strobe on the event itself, not the sticky bit
	assign intr = |(msk & sta_set);

endmodule

//--- hdl/fcp_tx_if.sv
// fcp_tx_if interface: tx events and levels from the sequencer to registers and shifter
`timescale 1ns/10ps

interface fcp_tx_if;

	logic start;      // idle write loads a frame (1T)
	logic reload;     // pending byte loaded at frame end (1T)
	logic shift;      // symbol end inside a frame (1T)
	logic dbuf_empty; // data register taken (1T)
	logic tx_end;     // last frame done, nothing pending (1T)
	logic keep_empty; // no byte waiting in the data register
	logic on_tx;      // frame on the line

	modport ctrl (output start, reload, shift, dbuf_empty, tx_end, keep_empty, on_tx);
	modport regs (input dbuf_empty, tx_end, keep_empty, on_tx);
	modport shft (input start, reload, shift, on_tx);

endinterface

//--- hdl/fcp_pkg.sv
// fcp package: write strobe indices, control/status bit positions, mode, state and frame types
package fcp_pkg;

	//----------------------------------------------------------------------
	// register write strobes, position in wr[3:0]
	localparam int reg_ctl = 0; // control
	localparam int reg_sta = 1; // status, write one to clear
	localparam int reg_msk = 2; // interrupt mask
	localparam int reg_dat = 3; // tx data byte

	// control bits, [4:0] stored, [7:5] read only
	localparam int ctl_sync       = 0; // leading sync symbols
	localparam int ctl_parity     = 1; // trailing odd parity
	localparam int ctl_en         = 4; // engine enable
	localparam int ctl_dn         = 5; // sensed D- level
	localparam int ctl_on_tx      = 6; // frame in progress
	localparam int ctl_keep_empty = 7; // no byte pending

	// status bits, rx bits 2..6 read zero
	localparam int sta_tx_end     = 0;
	localparam int sta_dbuf_empty = 1;
	localparam int sta_acc_int    = 7;

	//----------------------------------------------------------------------
	typedef struct packed {
		logic sync;   // sync symbols before the byte
		logic parity; // odd parity after the byte
	} fcp_mode_t;

	// sequencer states, one per framing mode
	typedef enum logic [2:0] {
		idle        = 3'd0,
		tx_plain    = 3'd1, // byte only
		tx_par      = 3'd2, // byte + parity
		tx_sync     = 3'd3, // sync + byte
		tx_sync_par = 3'd4  // sync + byte + parity
	} tx_state_t;

	typedef logic [11:0] frame_t;    // bit 11 drives the line
	typedef logic [1:0]  sync_len_t; // 0 no sync, else sync count minus one
	typedef logic [3:0]  sym_cnt_t;  // up to 12 symbols per frame

endpackage
